// ==== gpu_int_pkg.sv ====
/* Shared constants and types for the interrupt unit: register map, flag and status
   bit positions, service vector bases and the injected instruction word format */
`default_nettype none

package gpu_int_pkg;

	// Maximum number of interrupt sources (source 5 only in the DSP variant)
	localparam int num_src = 6;

	// APB byte offsets within the 4-bit window
	localparam logic [3:0] flags_addr = 4'h0;
	localparam logic [3:0] status_addr = 4'h4;

	// FLAGS register fields
	localparam int imask_bit = 3;
	localparam int ena_lsb = 4;
	localparam int clr_lsb = 9;
	localparam int ena5_bit = 16;
	localparam int clr5_bit = 17;

	// STATUS register fields, latched sources 0 to 4 then source 5
	localparam int stat_lsb = 6;
	localparam int stat5_bit = 16;

	// Service routine bases, 16 bytes per source
	localparam logic [31:0] vec_base_gpu = 32'h00F03000;
	localparam logic [31:0] vec_base_dsp = 32'h00F1B000;

	// Opcodes used by the service stub
	localparam logic [5:0] op_subqt = 6'd7;
	localparam logic [5:0] op_store = 6'd47;
	localparam logic [5:0] op_movei = 6'd38;
	localparam logic [5:0] op_move_pc = 6'd51;
	localparam logic [5:0] op_jump = 6'd52;
	localparam logic [5:0] op_nop = 6'd57;

	// Registers the stub touches
	localparam logic [4:0] reg_sp = 5'd31;
	localparam logic [4:0] reg_tmp = 5'd30;
	localparam logic [4:0] sp_step = 5'd4;

	// Two-operand instruction layout
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] op1;
		logic [4:0] op2;
	} gpu_op_t;

	// Instruction word seen either as opcode fields or as a raw immediate halfword
	typedef union packed {
		gpu_op_t op;
		logic [15:0] imm;
	} gpu_ins_t;

	// Source number, 0 to 5
	typedef logic [2:0] src_idx_t;

endpackage

`default_nettype wire

// ==== int_flag_regs.sv ====
/* APB slave for the FLAGS and STATUS registers. Holds the source enables and issues
   the latch-clear and mask-clear strobes on FLAGS writes */
`default_nettype none

module int_flag_regs #(
	parameter int dsp_variant = 0
) (
	input logic sys_clk,
	input logic resetl,
	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Status from the rest of the unit
	input logic [gpu_int_pkg::num_src-1:0] pending,
	input logic imask,
	// Controls out
	output logic [gpu_int_pkg::num_src-1:0] int_ena,
	output logic [gpu_int_pkg::num_src-1:0] lat_clr,
	output logic mask_clr
);
	import gpu_int_pkg::*;

	// Sources 0 to 4 sit in a contiguous field
	localparam int lo_cnt = num_src - 1;
	// Source 5 exists only in the DSP build
	localparam logic dsp_en = (dsp_variant != 0);

	logic access;
	logic flags_hit;
	logic status_hit;
	logic flags_wr;
	logic rd_en;

	// Zero wait states, done in the access phase
	assign access = psel & penable;
	assign pready = access;

	assign flags_hit = (paddr == flags_addr);
	assign status_hit = (paddr == status_addr);

	// Anything outside the two registers errors and is ignored
	assign pslverr = access & ~(flags_hit | status_hit);

	assign flags_wr = access & pwrite & flags_hit;
	assign rd_en = psel & ~pwrite;

	// Enables, bit 5 tied off in the GPU build
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			int_ena <= '0;
		end else if (flags_wr) begin
			int_ena[lo_cnt-1:0] <= pwdata[ena_lsb +: lo_cnt];
			int_ena[lo_cnt] <= pwdata[ena5_bit] & dsp_en;
		end
	end

	// Write-one-to-clear strobes, live only during the FLAGS write cycle
	always_comb begin
		lat_clr = '0;
		if (flags_wr) begin
			lat_clr[lo_cnt-1:0] = pwdata[clr_lsb +: lo_cnt];
			lat_clr[lo_cnt] = pwdata[clr5_bit] & dsp_en;
		end
	end

	// Writing 0 to the mask bit releases the global mask
	assign mask_clr = flags_wr & ~pwdata[imask_bit];

	// Read mux
	always_comb begin
		prdata = '0;
		if (rd_en && flags_hit) begin
			prdata[imask_bit] = imask;
			prdata[ena_lsb +: lo_cnt] = int_ena[lo_cnt-1:0];
			prdata[ena5_bit] = int_ena[lo_cnt];
		end else if (rd_en && status_hit) begin
			prdata[stat_lsb +: lo_cnt] = pending[lo_cnt-1:0];
			prdata[stat5_bit] = pending[lo_cnt];
		end
	end

endmodule

`default_nettype wire

// ==== int_source_latch.sv ====
/* Per-source interrupt latches and the fixed-priority encoder.
   The highest numbered pending source wins */
`default_nettype none

module int_source_latch (
	input logic sys_clk,
	input logic resetl,
	// Level-sensitive requests from the core's peripherals
	input logic [gpu_int_pkg::num_src-1:0] src_irq,
	input logic [gpu_int_pkg::num_src-1:0] int_ena,
	input logic [gpu_int_pkg::num_src-1:0] lat_clr,
	// Latched state and the encoded winner
	output logic [gpu_int_pkg::num_src-1:0] pending,
	output logic irq_any,
	output gpu_int_pkg::src_idx_t win_idx
);
	import gpu_int_pkg::*;

	logic [num_src-1:0] lat_set;
	logic [num_src-1:0] lat_hold;

	// Only enabled sources can set a latch
	assign lat_set = src_irq & int_ena;

	// A latch keeps its value until software clears it
	assign lat_hold = pending & ~lat_clr;

	// Set dominates clear in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pending <= '0;
		end else begin
			pending <= lat_set | lat_hold;
		end
	end

	assign irq_any = |pending;

	// Scan upward so the highest set index is the last one kept
	always_comb begin
		win_idx = '0;
		for (int i = 0; i < num_src; i++) begin
			if (pending[i]) begin
				win_idx = src_idx_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== int_vector_seq.sv ====
/* Interrupt service sequencer. Takes the interrupt, sets the global mask and feeds
   the core the eight-word stub that saves pc and jumps to the source vector */
`default_nettype none

module int_vector_seq #(
	parameter int dsp_variant = 0
) (
	input logic sys_clk,
	input logic resetl,
	// From the source latches
	input logic irq_any,
	input gpu_int_pkg::src_idx_t win_idx,
	// Core handshake
	input logic atomic,
	input logic ins_taken,
	// Software mask release
	input logic mask_clr,
	output logic in_service,
	output logic imask,
	output gpu_int_pkg::gpu_ins_t ins_word
);
	import gpu_int_pkg::*;

	localparam logic [31:0] vec_base = (dsp_variant != 0) ? vec_base_dsp : vec_base_gpu;

	logic srv_start;
	logic take;
	logic last_word;
	logic [2:0] word_cnt;
	logic [31:0] srv_addr;

	// Builds one opcode-form word
	function automatic gpu_ins_t mk_op(
		input logic [5:0] opcode,
		input logic [4:0] op1,
		input logic [4:0] op2
	);
		gpu_ins_t w;
		w.op.opcode = opcode;
		w.op.op1 = op1;
		w.op.op2 = op2;
		return w;
	endfunction

	// No nesting, and never inside an atomic sequence
	assign srv_start = irq_any & ~imask & ~atomic & ~in_service;

	// Words only count while the stub is being injected
	assign take = ins_taken & in_service;
	assign last_word = take & (word_cnt == 3'd7);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			in_service <= 1'b0;
		end else if (srv_start) begin
			in_service <= 1'b1;
		end else if (last_word) begin
			in_service <= 1'b0;
		end
	end

	// Hardware set beats a software clear
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			imask <= 1'b0;
		end else if (take) begin
			imask <= 1'b1;
		end else if (mask_clr) begin
			imask <= 1'b0;
		end
	end

	// Wraps back to 0 after the nop
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			word_cnt <= '0;
		end else if (take) begin
			word_cnt <= word_cnt + 3'd1;
		end
	end

	// 16 bytes per source vector, winner sampled live
	assign srv_addr = vec_base + {25'd0, win_idx, 4'h0};

	// Stub: subqt, move pc, store, movei + address, jump, nop
	always_comb begin
		ins_word = mk_op(op_nop, 5'd0, 5'd0);
		case (word_cnt)
			3'd0: ins_word = mk_op(op_subqt, sp_step, reg_sp);
			3'd1: ins_word = mk_op(op_move_pc, 5'd0, reg_tmp);
			3'd2: ins_word = mk_op(op_store, reg_sp, reg_tmp);
			3'd3: ins_word = mk_op(op_movei, 5'd0, reg_tmp);
			// movei immediate, low half first
			3'd4: ins_word.imm = srv_addr[15:0];
			3'd5: ins_word.imm = srv_addr[31:16];
			3'd6: ins_word = mk_op(op_jump, reg_tmp, 5'd0);
			default: ins_word = mk_op(op_nop, 5'd0, 5'd0);
		endcase
	end

endmodule

`default_nettype wire

// ==== gpu_int_top.sv ====
/* Interrupt unit top level. APB register access on one side, the core's
   interrupt sources and instruction injection on the other */
`default_nettype none

module gpu_int_top #(
	parameter int dsp_variant = 0
) (
	input logic sys_clk,
	input logic resetl,
	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Core side
	input logic [gpu_int_pkg::num_src-1:0] src_irq,
	input logic atomic,
	input logic ins_taken,
	output logic in_service,
	output gpu_int_pkg::gpu_ins_t ins_word
);
	import gpu_int_pkg::*;

	logic [num_src-1:0] int_ena;
	logic [num_src-1:0] lat_clr;
	logic [num_src-1:0] pending;
	logic mask_clr;
	logic imask;
	logic irq_any;
	src_idx_t win_idx;

	// Register file and strobes
	int_flag_regs #(
		.dsp_variant(dsp_variant)
	) u_int_flag_regs (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pending(pending),
		.imask(imask),
		.int_ena(int_ena),
		.lat_clr(lat_clr),
		.mask_clr(mask_clr)
	);

	// Latches and priority encoder
	int_source_latch u_int_source_latch (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.src_irq(src_irq),
		.int_ena(int_ena),
		.lat_clr(lat_clr),
		.pending(pending),
		.irq_any(irq_any),
		.win_idx(win_idx)
	);

	// Service state and stub injection
	int_vector_seq #(
		.dsp_variant(dsp_variant)
	) u_int_vector_seq (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.irq_any(irq_any),
		.win_idx(win_idx),
		.atomic(atomic),
		.ins_taken(ins_taken),
		.mask_clr(mask_clr),
		.in_service(in_service),
		.imask(imask),
		.ins_word(ins_word)
	);

endmodule

`default_nettype wire

// ==== tb_gpu_int.sv ====
/* Directed testbench for the interrupt unit. Drives APB and the core handshake
   through reset, latching, the service stub, masking and source 5 priority */
`default_nettype none

module tb_gpu_int;
	import gpu_int_pkg::*;

	// Five short tests with random gaps stay far below this
	localparam int cycle_limit = 2000;

	logic sys_clk;
	logic resetl;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [num_src-1:0] src_irq;
	logic atomic;
	logic ins_taken;
	logic in_service;
	gpu_ins_t ins_word;

	// Random state, last APB error flag, run length
	logic [31:0] rng;
	logic last_err;
	int cycle_cnt = 0;

	// DSP build so source 5 and the DSP vector base are exercised
	gpu_int_top #(
		.dsp_variant(1)
	) u_gpu_int_top (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.src_irq(src_irq),
		.atomic(atomic),
		.ins_taken(ins_taken),
		.in_service(in_service),
		.ins_word(ins_word)
	);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;

	// Watchdog
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: run went past %0d clock cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "simulation stopped by the watchdog");
		end
	end

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_ins(input string name, input gpu_ins_t exp, input gpu_ins_t act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected 0x%04h got 0x%04h", $time, name, exp, act);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// FLAGS as read back: mask at bit 3, enables 0-4 at 8:4, enable 5 at 16
	function automatic logic [31:0] flags_read_val(input logic mask, input logic [5:0] ena);
		logic [31:0] v;
		v = '0;
		v[imask_bit] = mask;
		v[ena_lsb +: 5] = ena[4:0];
		v[ena5_bit] = ena[5];
		return v;
	endfunction

	// FLAGS write data, bit 3 high leaves the mask alone
	function automatic logic [31:0] flags_write_val(input logic keep_mask,
			input logic [5:0] ena, input logic [5:0] clr);
		logic [31:0] v;
		v = flags_read_val(keep_mask, ena);
		v[clr_lsb +: 5] = clr[4:0];
		v[clr5_bit] = clr[5];
		return v;
	endfunction

	// STATUS: sources 0-4 at 10:6, source 5 at 16
	function automatic logic [31:0] status_val(input logic [5:0] pend);
		logic [31:0] v;
		v = '0;
		v[stat_lsb +: 5] = pend[4:0];
		v[stat5_bit] = pend[5];
		return v;
	endfunction

	// Highest set source wins
	function automatic src_idx_t highest_src(input logic [5:0] pat);
		src_idx_t idx;
		logic found;
		idx = '0;
		found = 1'b0;
		for (int i = 5; i >= 0; i--) begin
			if (pat[i] && !found) begin
				idx = 3'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic gpu_ins_t make_op_word(input logic [5:0] opc, input logic [4:0] a,
			input logic [4:0] b);
		gpu_ins_t w;
		w.op.opcode = opc;
		w.op.op1 = a;
		w.op.op2 = b;
		return w;
	endfunction

	// Expected stub word k for the given winning source
	function automatic gpu_ins_t stub_word(input logic [2:0] k, input src_idx_t idx);
		gpu_ins_t w;
		logic [31:0] addr;
		addr = vec_base_dsp + 32'(idx) * 32'd16;
		case (k)
			3'd0: w = make_op_word(op_subqt, 5'd4, 5'd31);
			3'd1: w = make_op_word(op_move_pc, 5'd0, 5'd30);
			3'd2: w = make_op_word(op_store, 5'd31, 5'd30);
			3'd3: w = make_op_word(op_movei, 5'd0, 5'd30);
			3'd4: w.imm = addr[15:0];
			3'd5: w.imm = addr[31:16];
			3'd6: w = make_op_word(op_jump, 5'd30, 5'd0);
			default: w = make_op_word(op_nop, 5'd0, 5'd0);
		endcase
		return w;
	endfunction

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge sys_clk);
		#2;
		penable = 1'b1;
		// Access phase ends once pready is seen
		@(negedge sys_clk);
		while (!pready) begin
			@(negedge sys_clk);
		end
		last_err = pslverr;
		@(posedge sys_clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge sys_clk);
		#2;
		penable = 1'b1;
		@(negedge sys_clk);
		while (!pready) begin
			@(negedge sys_clk);
		end
		data = prdata;
		last_err = pslverr;
		@(posedge sys_clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// One core fetch of an injected word
	task automatic pulse_taken();
		@(posedge sys_clk);
		#2;
		ins_taken = 1'b1;
		@(posedge sys_clk);
		#2;
		ins_taken = 1'b0;
	endtask

	task automatic pulse_sources(input logic [5:0] pat);
		@(posedge sys_clk);
		#2;
		src_irq = pat;
		@(posedge sys_clk);
		#2;
		src_irq = '0;
	endtask

	task automatic set_atomic(input logic v);
		@(posedge sys_clk);
		#2;
		atomic = v;
	endtask

	// Bounded by the watchdog
	task automatic wait_service();
		@(negedge sys_clk);
		while (!in_service) begin
			@(negedge sys_clk);
		end
	endtask

	// Takes all eight words with random gaps and checks each one
	task automatic run_stub(input src_idx_t idx, output gpu_ins_t addr_lo,
			output gpu_ins_t addr_hi);
		logic [31:0] r;
		for (int k = 0; k < 8; k++) begin
			next_rand(r);
			repeat (r[1:0]) @(posedge sys_clk);
			@(negedge sys_clk);
			check_bit("in_service", 1'b1, in_service);
			check_ins($sformatf("ins_word[%0d]", k), stub_word(3'(k), idx), ins_word);
			if (k == 4) begin
				addr_lo = ins_word;
			end
			if (k == 5) begin
				addr_hi = ins_word;
			end
			pulse_taken();
		end
		@(negedge sys_clk);
		check_bit("in_service", 1'b0, in_service);
	endtask

	task automatic test_reset_readback();
		logic [31:0] r;
		logic [31:0] rd;
		logic [5:0] ena;
		@(negedge sys_clk);
		check_bit("in_service", 1'b0, in_service);
		check_bit("pready", 1'b0, pready);
		check_bit("pslverr", 1'b0, pslverr);
		apb_read(flags_addr, rd);
		check_word("flags", 32'h0, rd);
		check_bit("pslverr", 1'b0, last_err);
		apb_read(status_addr, rd);
		check_word("status", 32'h0, rd);
		next_rand(r);
		ena = r[5:0];
		apb_write(flags_addr, flags_write_val(1'b0, ena, 6'd0));
		apb_read(flags_addr, rd);
		check_word("flags", flags_read_val(1'b0, ena), rd);
		// Unmapped offsets error out and leave FLAGS as it was
		apb_read(4'h8, rd);
		check_bit("pslverr", 1'b1, last_err);
		apb_write(4'hC, flags_write_val(1'b0, ~ena, 6'd0));
		check_bit("pslverr", 1'b1, last_err);
		apb_read(flags_addr, rd);
		check_word("flags", flags_read_val(1'b0, ena), rd);
	endtask

	task automatic test_latch_clear();
		logic [31:0] r;
		logic [31:0] rd;
		logic [5:0] ena;
		logic [5:0] pat;
		logic [5:0] clr;
		logic [5:0] expect_pend;
		src_idx_t off;
		// Atomic keeps service from starting while latches are played with
		set_atomic(1'b1);
		next_rand(r);
		off = 3'(r[15:8] % 8'd5) + 3'd1;
		ena = r[5:0] | 6'd1;
		ena[off] = 1'b0;
		apb_write(flags_addr, flags_write_val(1'b0, ena, 6'h3F));
		// Disabled sources are always pulsed too
		next_rand(r);
		pat = r[5:0] | ~ena;
		pulse_sources(pat);
		expect_pend = pat & ena;
		apb_read(status_addr, rd);
		check_word("status", status_val(expect_pend), rd);
		next_rand(r);
		clr = r[5:0];
		apb_write(flags_addr, flags_write_val(1'b0, ena, clr));
		expect_pend = expect_pend & ~clr;
		apb_read(status_addr, rd);
		check_word("status", status_val(expect_pend), rd);
		// Source 0 pulses in the same cycle as its clear
		@(posedge sys_clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = flags_addr;
		pwdata = flags_write_val(1'b0, ena, 6'd1);
		@(posedge sys_clk);
		#2;
		penable = 1'b1;
		src_irq = 6'd1;
		@(posedge sys_clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		src_irq = '0;
		expect_pend[0] = 1'b1;
		apb_read(status_addr, rd);
		check_word("status", status_val(expect_pend), rd);
		apb_write(flags_addr, flags_write_val(1'b0, 6'd0, 6'h3F));
		apb_read(status_addr, rd);
		check_word("status", 32'h0, rd);
		check_bit("in_service", 1'b0, in_service);
	endtask

	task automatic test_service_stub();
		logic [31:0] r;
		logic [31:0] rd;
		logic [5:0] pat;
		gpu_ins_t lo;
		gpu_ins_t hi;
		apb_write(flags_addr, flags_write_val(1'b0, 6'h3F, 6'd0));
		next_rand(r);
		pat = r[5:0];
		if (pat == 6'd0) begin
			pat = 6'd1;
		end
		pulse_sources(pat);
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		check_bit("in_service", 1'b0, in_service);
		apb_read(status_addr, rd);
		check_word("status", status_val(pat), rd);
		set_atomic(1'b0);
		wait_service();
		run_stub(highest_src(pat), lo, hi);
		// Mask was set by the first fetch
		apb_read(flags_addr, rd);
		check_word("flags", flags_read_val(1'b1, 6'h3F), rd);
	endtask

	task automatic test_mask_blocks();
		logic [31:0] r;
		logic [31:0] rd;
		logic [5:0] pat;
		logic [5:0] clr;
		gpu_ins_t lo;
		gpu_ins_t hi;
		// New pending set, bit 3 high so the mask stays
		apb_write(flags_addr, flags_write_val(1'b1, 6'h3F, 6'h3F));
		next_rand(r);
		pat = r[5:0] | 6'd1;
		pulse_sources(pat);
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		check_bit("in_service", 1'b0, in_service);
		apb_read(flags_addr, rd);
		check_word("flags", flags_read_val(1'b1, 6'h3F), rd);
		apb_read(status_addr, rd);
		check_word("status", status_val(pat), rd);
		// Drop the top source unless it is the only one, and release the mask
		clr = '0;
		if (pat != 6'd1) begin
			clr[highest_src(pat)] = 1'b1;
		end
		apb_write(flags_addr, flags_write_val(1'b0, 6'h3F, clr));
		wait_service();
		run_stub(highest_src(pat & ~clr), lo, hi);
	endtask

	task automatic test_src5_priority();
		logic [31:0] r;
		logic [31:0] rd;
		logic [5:0] pat;
		gpu_ins_t lo;
		gpu_ins_t hi;
		apb_write(flags_addr, flags_write_val(1'b1, 6'h3F, 6'h3F));
		next_rand(r);
		pat = 6'b100000;
		pat[3'(r[7:0] % 8'd5)] = 1'b1;
		pulse_sources(pat);
		apb_read(status_addr, rd);
		check_word("status", status_val(pat), rd);
		apb_write(flags_addr, flags_write_val(1'b0, 6'h3F, 6'd0));
		wait_service();
		run_stub(3'd5, lo, hi);
		check_word("service address", 32'h00F1B050, {hi.imm, lo.imm});
		apb_write(flags_addr, flags_write_val(1'b1, 6'd0, 6'h3F));
		apb_read(status_addr, rd);
		check_word("status", 32'h0, rd);
	endtask

	initial begin
		resetl = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		src_irq = '0;
		atomic = 1'b0;
		ins_taken = 1'b0;
		last_err = 1'b0;
		rng = 32'd58;
		repeat (2) @(posedge sys_clk);
		#2;
		resetl = 1'b1;
		test_reset_readback();
		test_latch_clear();
		test_service_stub();
		test_mask_blocks();
		test_src5_priority();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
gpu_int_pkg.sv
int_flag_regs.sv
int_source_latch.sv
int_vector_seq.sv
gpu_int_top.sv
tb_gpu_int.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the interrupt unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_gpu_int -o sim_tb_gpu_int

# The simulator output goes to the terminal and is searched for the pass line
if ./obj_dir/sim_tb_gpu_int | tee /dev/stderr | grep "Test completed successfully" > /dev/null; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
